//--- build.f
design/cmp_pkg.sv
design/cmp_mode_select.sv
design/cmp_burst_ctrl.sv
design/cmp_intf_top.sv
verification/cmp_intf_assert.sv
verification/tb_cmp_intf.sv

//--- design/cmp_burst_ctrl.sv
`timescale 1ns/100ps

module cmp_burst_ctrl #(
  parameter int unsigned DATA_W = 64
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // size FIFO heads, show-ahead
  input  cmp_pkg::src_size_t   sr_size_i,
  input  cmp_pkg::src_size_t   zrl_size_i,
  input  cmp_pkg::src_size_t   bpc_size_i,
  // data FIFO full flags
  input  cmp_pkg::src_flags_t  d_full_i,
  // burst plan from the mode selector
  input  cmp_pkg::burst_plan_t plan_i,
  // data FIFO heads, show-ahead
  input  logic [DATA_W-1:0]    sr_data_i,
  input  logic [DATA_W-1:0]    zrl_data_i,
  input  logic [DATA_W-1:0]    bpc_data_i,
  // memory side
  input  logic                 ready_i,
  output logic                 valid_o,
  output logic                 sop_o,
  output logic                 eop_o,
  output logic [DATA_W-1:0]    data_o,
  // FIFO pops
  output cmp_pkg::src_flags_t  data_rd_o,
  output logic                 size_rd_o,
  // compressor side
  output logic                 ready_o
);

  localparam int unsigned CNT_W = cmp_pkg::CNT_W;

  // index of the final beat in a burst
  localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(cmp_pkg::BURST_LEN - 1);
  // sr always fills the whole burst
  localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(cmp_pkg::BURST_LEN);

  // --------------------
  // handshake
  // --------------------

  logic valid;
  logic xfer;

  // a block is ready once every compressor has posted its size
  assign valid = ~(sr_size_i.empty | zrl_size_i.empty | bpc_size_i.empty);
  // beat moves on valid and ready together
  assign xfer  = valid & ready_i;

  assign valid_o = valid;

  // --------------------
  // beat counter
  // --------------------

  logic [CNT_W-1:0] beat_q;
  logic [CNT_W-1:0] beat_d;
  logic             last_beat;

  assign last_beat = beat_q == LAST_BEAT;

  // step per transfer, wrap after the last beat
  // holds under back-pressure
  always_comb begin
    beat_d = beat_q;
    if (xfer) begin
      if (last_beat) begin
        beat_d = '0;
      end else begin
        beat_d = beat_q + CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_q <= '0;
    end else begin
      beat_q <= beat_d;
    end
  end

  // --------------------
  // framing
  // --------------------

  // markers qualify the beat on the bus
  // they stay up while the beat waits for ready
  assign sop_o = valid & (beat_q == '0);
  assign eop_o = valid & last_beat;

  // size heads go away only with the last beat
  // so plan and valid hold through the burst
  assign size_rd_o = xfer & last_beat;

  // --------------------
  // padding
  // --------------------

  logic [CNT_W-1:0] sel_cnt;
  logic             pad;

  // block count of the source on the bus
  always_comb begin
    case (plan_i.mode)
      cmp_pkg::MODE_SR: begin
        sel_cnt = FULL_CNT;
      end
      cmp_pkg::MODE_ZRL: begin
        sel_cnt = plan_i.zrl_cnt;
      end
      cmp_pkg::MODE_BPC: begin
        sel_cnt = plan_i.bpc_cnt;
      end
      default: begin
        sel_cnt = '0;
      end
    endcase
  end

  // beats past the compressed blocks carry zeros
  assign pad = beat_q >= sel_cnt;

  // --------------------
  // drain strobes
  // --------------------

  // each source drops exactly the words it wrote
  // independent of which one got selected
  always_comb begin
    // sr writes a full burst every time
    data_rd_o.sr  = xfer;
    data_rd_o.zrl = xfer & (beat_q < plan_i.zrl_cnt);
    data_rd_o.bpc = xfer & (beat_q < plan_i.bpc_cnt);
  end

  // --------------------
  // data out
  // --------------------

  // zero when idle or padding, otherwise the selected head
  always_comb begin
    data_o = '0;
    if (valid && !pad) begin
      case (plan_i.mode)
        cmp_pkg::MODE_SR: begin
          data_o = sr_data_i;
        end
        cmp_pkg::MODE_ZRL: begin
          data_o = zrl_data_i;
        end
        cmp_pkg::MODE_BPC: begin
          data_o = bpc_data_i;
        end
        default: begin
          data_o = '0;
        end
      endcase
    end
  end

  // --------------------
  // upstream ready
  // --------------------

  logic any_full;
  logic any_th;

  assign any_full = d_full_i.sr | d_full_i.zrl | d_full_i.bpc;
  // size FIFO close to full, stop before it overflows
  assign any_th   = sr_size_i.th | zrl_size_i.th | bpc_size_i.th;

  // compressors run only while the memory side drains
  assign ready_o = ready_i & ~any_full & ~any_th;

endmodule

//--- design/cmp_intf_top.sv
`timescale 1ns/100ps

module cmp_intf_top #(
  parameter int unsigned DATA_W = 64
) (
  input  logic                clk,
  input  logic                rst_n,
  // --------------------
  // compressor FIFOs
  // --------------------
  // size heads
  input  cmp_pkg::src_size_t  sr_size_i,
  input  cmp_pkg::src_size_t  zrl_size_i,
  input  cmp_pkg::src_size_t  bpc_size_i,
  // data FIFO full flags
  input  cmp_pkg::src_flags_t d_full_i,
  // data heads
  input  logic [DATA_W-1:0]   sr_data_i,
  input  logic [DATA_W-1:0]   zrl_data_i,
  input  logic [DATA_W-1:0]   bpc_data_i,
  // FIFO pops
  output cmp_pkg::src_flags_t data_rd_o,
  output logic                size_rd_o,
  // --------------------
  // memory side
  // --------------------
  input  logic                ready_i,
  output logic                valid_o,
  output logic                sop_o,
  output logic                eop_o,
  output logic [DATA_W-1:0]   data_o,
  // back to the compressor inputs
  output logic                ready_o
);

  // mode and block counts of the block at the FIFO heads
  cmp_pkg::burst_plan_t plan;

  // size heads to burst plan
  cmp_mode_select i_cmp_mode_select (
    .sr_size_i  (sr_size_i),
    .zrl_size_i (zrl_size_i),
    .bpc_size_i (bpc_size_i),
    .plan_o     (plan)
  );

  // burst sequencing and FIFO drain
  cmp_burst_ctrl #(
    .DATA_W (DATA_W)
  ) i_cmp_burst_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .sr_size_i  (sr_size_i),
    .zrl_size_i (zrl_size_i),
    .bpc_size_i (bpc_size_i),
    .d_full_i   (d_full_i),
    .plan_i     (plan),
    .sr_data_i  (sr_data_i),
    .zrl_data_i (zrl_data_i),
    .bpc_data_i (bpc_data_i),
    .ready_i    (ready_i),
    .valid_o    (valid_o),
    .sop_o      (sop_o),
    .eop_o      (eop_o),
    .data_o     (data_o),
    .data_rd_o  (data_rd_o),
    .size_rd_o  (size_rd_o),
    .ready_o    (ready_o)
  );

endmodule

//--- design/cmp_mode_select.sv
`timescale 1ns/100ps

module cmp_mode_select (
  input  cmp_pkg::src_size_t   sr_size_i,
  input  cmp_pkg::src_size_t   zrl_size_i,
  input  cmp_pkg::src_size_t   bpc_size_i,
  output cmp_pkg::burst_plan_t plan_o
);

  // package widths
  localparam int unsigned SIZE_W = cmp_pkg::SIZE_W;
  localparam int unsigned SUM_W  = cmp_pkg::SIZE_W + 1;
  localparam int unsigned CNT_W  = cmp_pkg::CNT_W;
  // granule is a power of two
  // divide by shifting
  localparam int unsigned SHIFT  = $clog2(cmp_pkg::GRANULE_BITS);

  // --------------------
  // block count
  // --------------------

  // bits to blocks, rounded up
  // a block larger than the burst is clamped
  // that source failed anyway
  function automatic logic [CNT_W-1:0] block_cnt(input logic [SIZE_W-1:0] size);
    logic [SUM_W-1:0] rounded;
    logic [SUM_W-1:0] blocks;
    // extra msb keeps the carry of the rounding add
    rounded = {1'b0, size} + SUM_W'(cmp_pkg::GRANULE_BITS - 1);
    blocks  = rounded >> SHIFT;
    if (blocks > SUM_W'(cmp_pkg::BURST_LEN)) begin
      return CNT_W'(cmp_pkg::BURST_LEN);
    end
    return blocks[CNT_W-1:0];
  endfunction

  // --------------------
  // ok flags
  // --------------------

  logic sr_ok;
  logic zrl_ok;

  always_comb begin
    // sr reports pass/fail in bit 0
    sr_ok  = ~sr_size_i.size[0];
    // zrl passes when no larger than raw
    zrl_ok = zrl_size_i.size <= SIZE_W'(cmp_pkg::RAW_LIMIT);
  end

  // --------------------
  // mode priority
  // --------------------

  cmp_pkg::mode_e mode;

  // sr first, then zrl, bpc last
  always_comb begin
    casez ({sr_ok, zrl_ok})
      2'b1?: begin
        mode = cmp_pkg::MODE_SR;
      end
      2'b01: begin
        mode = cmp_pkg::MODE_ZRL;
      end
      default: begin
        // bpc takes the rest
        // also the block that nothing compressed
        mode = cmp_pkg::MODE_BPC;
      end
    endcase
  end

  // --------------------
  // plan out
  // --------------------

  // pure function of the size heads
  // stable for as long as the heads are not popped
  always_comb begin
    plan_o.mode    = mode;
    plan_o.zrl_cnt = block_cnt(zrl_size_i.size);
    plan_o.bpc_cnt = block_cnt(bpc_size_i.size);
  end

endmodule

//--- design/cmp_pkg.sv
package cmp_pkg;

  // --------------------
  // burst and size constants
  // --------------------

  // beats per memory burst
  localparam int unsigned BURST_LEN = 8;

  // one data block per beat, counted in bits by the size words
  localparam int unsigned GRANULE_BITS = 64;

  // width of a size FIFO word
  localparam int unsigned SIZE_W = 11;

  // largest compressed size that still beats raw data
  localparam int unsigned RAW_LIMIT = 512;

  // beat index and block count, zero up to BURST_LEN inclusive
  localparam int unsigned CNT_W = $clog2(BURST_LEN + 1);

  // --------------------
  // mode encoding
  // --------------------

  // 2'b00 is never produced by the selector
  typedef enum logic [1:0] {
    MODE_SR  = 2'b01,
    MODE_ZRL = 2'b10,
    MODE_BPC = 2'b11
  } mode_e;

  // --------------------
  // shared structs
  // --------------------

  // head of one show-ahead size FIFO
  // for sr only size[0] is meaningful, set means compression failed
  typedef struct packed {
    logic              empty;
    logic              th;
    logic [SIZE_W-1:0] size;
  } src_size_t;

  // one bit per compressor
  // full flags, read strobes
  typedef struct packed {
    logic sr;
    logic zrl;
    logic bpc;
  } src_flags_t;

  // what the output side emits for the current block
  // counts are already clamped to BURST_LEN
  typedef struct packed {
    mode_e            mode;
    logic [CNT_W-1:0] zrl_cnt;
    logic [CNT_W-1:0] bpc_cnt;
  } burst_plan_t;

endpackage

//--- run.sh
#!/bin/sh
# build and run tb_cmp_intf with Verilator, result taken from sim.log

verilator --binary --timing --timescale 1ns/100ps --top-module tb_cmp_intf \
    -f build.f -o tb_cmp_intf \
  && ./obj_dir/tb_cmp_intf > sim.log 2>&1 \
  && cat sim.log \
  && ! grep -q "Test failures found" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- verification/cmp_intf_assert.sv
`timescale 1ns/100ps

module cmp_intf_assert (
  input logic                clk,
  input logic                rst_n,
  input logic                ready_i,
  input logic                valid_o,
  input logic                sop_o,
  input logic                eop_o,
  input cmp_pkg::src_flags_t data_rd_o,
  input logic                size_rd_o
);

  // --------------------
  // pop strobes
  // --------------------

  // nothing leaves a FIFO unless the memory side takes the beat
  a_rd_needs_ready : assert property (
    @(posedge clk) disable iff (!rst_n) (|data_rd_o || size_rd_o) |-> ready_i
  ) else $error("FIFO pop while ready_i is low");

  // size heads go only with the last beat
  a_size_rd_on_eop : assert property (
    @(posedge clk) disable iff (!rst_n) size_rd_o |-> eop_o
  ) else $error("size_rd_o outside the last beat");

  // --------------------
  // framing
  // --------------------

  // burst spans more than one beat
  a_sop_eop_apart : assert property (
    @(posedge clk) disable iff (!rst_n) !(sop_o && eop_o)
  ) else $error("sop_o and eop_o on the same beat");

  // a stalled beat stays on the bus
  a_valid_holds : assert property (
    @(posedge clk) disable iff (!rst_n) (valid_o && !ready_i) |=> valid_o
  ) else $error("valid_o dropped while ready_i was low");

endmodule

// attach to every burst controller
bind cmp_burst_ctrl cmp_intf_assert i_cmp_intf_assert (.*);

//--- verification/tb_cmp_intf.sv
`timescale 1ns/100ps

module tb_cmp_intf;

  localparam int unsigned DATA_W     = 64;
  localparam int unsigned BURST_LEN  = cmp_pkg::BURST_LEN;
  // six tests, each well under 300 cycles
  localparam int unsigned MAX_CYCLES = 2000;

  logic                clk = 1'b0;
  logic                rst_n;
  cmp_pkg::src_size_t  sr_size_i;
  cmp_pkg::src_size_t  zrl_size_i;
  cmp_pkg::src_size_t  bpc_size_i;
  cmp_pkg::src_flags_t d_full_i;
  logic [DATA_W-1:0]   sr_data_i;
  logic [DATA_W-1:0]   zrl_data_i;
  logic [DATA_W-1:0]   bpc_data_i;
  cmp_pkg::src_flags_t data_rd_o;
  logic                size_rd_o;
  logic                ready_i;
  logic                valid_o;
  logic                sop_o;
  logic                eop_o;
  logic [DATA_W-1:0]   data_o;
  logic                ready_o;

  // --------------------
  // FIFO models
  // --------------------

  // index 0 sr, 1 zrl, 2 bpc
  int unsigned loaded [3];
  int unsigned popped [3] = '{0, 0, 0};
  // a block is pending while loaded runs ahead of done
  int unsigned blocks_loaded;
  int unsigned blocks_done = 0;
  logic        blk_empty;
  cmp_pkg::src_flags_t hold_empty;
  cmp_pkg::src_flags_t th;
  logic        sr_fail;
  logic [cmp_pkg::SIZE_W-1:0] zrl_bits;
  logic [cmp_pkg::SIZE_W-1:0] bpc_bits;

  int          seed = 32'hd6d6;
  int unsigned check_cnt;
  int unsigned check_errs;
  int unsigned timeout_errs = 0;

  // source id on top, word index below
  function automatic logic [DATA_W-1:0] make_word(input int unsigned src,
                                                  input int unsigned idx);
    return {src + 32'd1, idx};
  endfunction

  // bits to beats, rounded up and clamped
  function automatic int unsigned blocks(input int unsigned bits);
    int unsigned n;
    n = (bits + cmp_pkg::GRANULE_BITS - 1) / cmp_pkg::GRANULE_BITS;
    return (n > BURST_LEN) ? BURST_LEN : n;
  endfunction

  assign blk_empty  = blocks_done == blocks_loaded;
  assign sr_size_i  = {blk_empty | hold_empty.sr, th.sr,
                       {(cmp_pkg::SIZE_W - 1){1'b0}}, sr_fail};
  assign zrl_size_i = {blk_empty | hold_empty.zrl, th.zrl, zrl_bits};
  assign bpc_size_i = {blk_empty | hold_empty.bpc, th.bpc, bpc_bits};

  // show-ahead heads, zero once drained
  always_comb begin
    sr_data_i  = (popped[0] < loaded[0]) ? make_word(0, popped[0]) : '0;
    zrl_data_i = (popped[1] < loaded[1]) ? make_word(1, popped[1]) : '0;
    bpc_data_i = (popped[2] < loaded[2]) ? make_word(2, popped[2]) : '0;
  end

  // pops take effect on the rising edge
  always @(posedge clk) begin
    if (data_rd_o.sr) begin
      popped[0] <= popped[0] + 1;
    end
    if (data_rd_o.zrl) begin
      popped[1] <= popped[1] + 1;
    end
    if (data_rd_o.bpc) begin
      popped[2] <= popped[2] + 1;
    end
    if (size_rd_o) begin
      blocks_done <= blocks_done + 1;
    end
  end

  always #2 clk = ~clk;

  cmp_intf_top #(.DATA_W(DATA_W)) i_cmp_intf_top (.*);

  // --------------------
  // check and summary
  // --------------------

  task automatic check_value(input string name, input logic [63:0] act,
                             input logic [63:0] exp);
    check_cnt++;
    if (act !== exp) begin
      check_errs++;
      $display("[ERROR] %s: expected %h, got %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic print_summary();
    $display("checks %0d, value errors %0d, timeouts %0d",
             check_cnt, check_errs, timeout_errs);
    if (check_errs == 0 && timeout_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
  endtask

  // --------------------
  // tests
  // --------------------

  // one block through a full burst, beat by beat
  task automatic run_burst(input logic fail, input int unsigned zbits,
                           input int unsigned bbits, input bit throttle);
    int unsigned cnt [3];
    int unsigned base [3];
    int unsigned sel;
    int unsigned beat;
    logic [DATA_W-1:0] exp_data;
    logic [2:0] exp_rd;
    logic exp_last;
    cnt[0] = BURST_LEN;
    cnt[1] = blocks(zbits);
    cnt[2] = blocks(bbits);
    // sr, then zrl if within raw, else bpc
    sel = !fail ? 0 : (zbits <= cmp_pkg::RAW_LIMIT) ? 1 : 2;
    @(negedge clk);
    for (int s = 0; s < 3; s++) begin
      base[s]   = popped[s];
      loaded[s] = popped[s] + BURST_LEN;
    end
    sr_fail  = fail;
    zrl_bits = zbits[cmp_pkg::SIZE_W-1:0];
    bpc_bits = bbits[cmp_pkg::SIZE_W-1:0];
    blocks_loaded++;
    beat = 0;
    while (beat < BURST_LEN) begin
      ready_i = throttle ? 1'($random(seed)) : 1'b1;
      @(posedge clk);
      exp_data = (beat < cnt[sel]) ? make_word(sel, base[sel] + beat) : '0;
      check_value("valid_o", 64'(valid_o), 64'd1);
      check_value("data_o", data_o, exp_data);
      check_value("sop_o", 64'(sop_o), 64'(beat == 0));
      check_value("eop_o", 64'(eop_o), 64'(beat == BURST_LEN - 1));
      exp_rd   = 3'b000;
      exp_last = 1'b0;
      if (ready_i) begin
        exp_rd   = {1'b1, beat < cnt[1], beat < cnt[2]};
        exp_last = beat == BURST_LEN - 1;
        beat++;
      end
      check_value("data_rd_o", 64'(data_rd_o), 64'(exp_rd));
      check_value("size_rd_o", 64'(size_rd_o), 64'(exp_last));
      @(negedge clk);
    end
    ready_i = 1'b1;
    // size heads gone, leftovers show the drain counts
    check_value("valid_o", 64'(valid_o), 64'd0);
    check_value("sr left", 64'(loaded[0] - popped[0]), 64'(BURST_LEN - cnt[0]));
    check_value("zrl left", 64'(loaded[1] - popped[1]), 64'(BURST_LEN - cnt[1]));
    check_value("bpc left", 64'(loaded[2] - popped[2]), 64'(BURST_LEN - cnt[2]));
  endtask

  // zrl size FIFO empty, nothing may move
  task automatic test_idle();
    @(negedge clk);
    for (int s = 0; s < 3; s++) begin
      loaded[s] = popped[s] + BURST_LEN;
    end
    sr_fail = 1'b0;
    hold_empty.zrl = 1'b1;
    blocks_loaded++;
    repeat (20) begin
      ready_i = 1'($random(seed));
      @(posedge clk);
      check_value("valid_o", 64'(valid_o), 64'd0);
      check_value("data_o", data_o, '0);
      check_value("data_rd_o", 64'(data_rd_o), 64'd0);
      check_value("size_rd_o", 64'(size_rd_o), 64'd0);
      @(negedge clk);
    end
    hold_empty = '0;
    blocks_loaded--;
    for (int s = 0; s < 3; s++) begin
      loaded[s] = popped[s];
    end
  endtask

  // every full, th and ready combination
  task automatic test_upstream_ready();
    for (int i = 0; i < 128; i++) begin
      @(negedge clk);
      d_full_i = 3'(i);
      th       = 3'(i >> 3);
      ready_i  = 1'(i >> 6);
      @(posedge clk);
      check_value("ready_o", 64'(ready_o), 64'(ready_i && !(|d_full_i) && !(|th)));
    end
    @(negedge clk);
    d_full_i = '0;
    th       = '0;
    ready_i  = 1'b1;
  endtask

  initial begin
    rst_n         = 1'b0;
    ready_i       = 1'b0;
    d_full_i      = '0;
    th            = '0;
    hold_empty    = '0;
    sr_fail       = 1'b0;
    zrl_bits      = '0;
    bpc_bits      = '0;
    blocks_loaded = 0;
    check_cnt     = 0;
    check_errs    = 0;
    loaded        = '{0, 0, 0};
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // sr selected, zrl 5 and bpc 2 drained
    run_burst(1'b0, 300, 100, 1'b0);
    // zrl with four padded beats
    run_burst(1'b1, 200, 600, 1'b0);
    // nothing compressed, bpc carries it
    run_burst(1'b1, 700, 900, 1'b0);
    // zrl again under random ready
    run_burst(1'b1, 200, 600, 1'b1);
    test_idle();
    test_upstream_ready();
    print_summary();
    $finish;
  end

  // watchdog
  initial begin
    repeat (MAX_CYCLES) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
    timeout_errs = 1;
    print_summary();
    $finish;
  end

endmodule
